// File: design/icb_splt_macros.svh
/*
 * bus splitter constants: bus widths, port count, region boundary,
 * order queue depth and the base address of each region port
 */
`ifndef ICB_SPLT_MACROS_SVH
`define ICB_SPLT_MACROS_SVH

`define ICB_AW          32
`define ICB_DW          64
`define ICB_MW          (`ICB_DW / 8)

// ports 0 to 4 own a region, the last port is the default
`define ICB_PORT_NUM    6

`define ICB_REGION_LSB  12
`define ICB_OUTS_DEPTH  4

`define ICB_BASE0       32'h1000_0000
`define ICB_BASE1       32'h1000_1000
`define ICB_BASE2       32'h2000_0000
`define ICB_BASE3       32'h4000_0000
`define ICB_BASE4       32'h8000_0000

`endif

// File: design/icb_bus_pkg.sv
/*
 * bus payload types, with the address word seen either raw
 * or as a region tag plus offset
 */
`default_nettype none

`include "icb_splt_macros.svh"

package icb_bus_pkg;

  typedef struct packed {
    logic [`ICB_AW-1:`ICB_REGION_LSB] tag;   // compared against a port base
    logic [`ICB_REGION_LSB-1:0]       ofs;   // offset inside the region
  } icb_addr_region_t;

  typedef union packed {
    logic [`ICB_AW-1:0] raw;
    icb_addr_region_t   region;
  } icb_addr_t;

  typedef logic [`ICB_DW-1:0] icb_data_t;

  typedef logic [`ICB_MW-1:0] icb_mask_t;   // one bit per data byte

endpackage

`default_nettype wire

// File: design/icb_route_pkg.sv
/*
 * routing types: downstream port number and one-hot port select
 */
`default_nettype none

`include "icb_splt_macros.svh"

package icb_route_pkg;

  // three bits cover all six ports
  typedef logic [2:0] icb_port_idx_t;

  typedef logic [`ICB_PORT_NUM-1:0] icb_port_sel_t;

endpackage

`default_nettype wire

// File: design/icb_addr_decode.sv
/*
 * command stage: decodes the target port from the address region
 * and holds one command with its port select for the dispatcher
 */
`timescale 1ns/1ps
`default_nettype none

`include "icb_splt_macros.svh"

module icb_addr_decode (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_cmd_valid,
  output logic                        o_cmd_ready,
  input  logic                        i_cmd_read,
  input  icb_bus_pkg::icb_addr_t      i_cmd_addr,
  input  icb_bus_pkg::icb_data_t      i_cmd_wdata,
  input  icb_bus_pkg::icb_mask_t      i_cmd_wmask,
  input  logic [`ICB_PORT_NUM-2:0]    i_port_enable,
  output logic                        o_stg_valid,
  input  logic                        i_stg_ready,
  output logic                        o_stg_read,
  output icb_bus_pkg::icb_addr_t      o_stg_addr,
  output icb_bus_pkg::icb_data_t      o_stg_wdata,
  output icb_bus_pkg::icb_mask_t      o_stg_wmask,
  output icb_route_pkg::icb_port_sel_t o_stg_sel
);

  localparam logic [`ICB_AW-1:0] BASE_ADDR [`ICB_PORT_NUM-1] = '{
    `ICB_BASE0,
    `ICB_BASE1,
    `ICB_BASE2,
    `ICB_BASE3,
    `ICB_BASE4
  };

  logic [`ICB_PORT_NUM-2:0]     region_hit;
  logic                         region_found;
  icb_route_pkg::icb_port_sel_t sel_nxt;
  logic                         cmd_hsk;

  for (genvar k = 0; k < `ICB_PORT_NUM - 1; k++) begin : g_hit
    assign region_hit[k] = i_port_enable[k] &
        (i_cmd_addr.region.tag == BASE_ADDR[k][`ICB_AW-1:`ICB_REGION_LSB]);
  end

  // Lowest matching port wins, anything unclaimed falls to the default port.
  always_comb begin
    sel_nxt      = '0;
    region_found = 1'b0;
    for (int k = 0; k < `ICB_PORT_NUM - 1; k++) begin
      if (region_hit[k] && !region_found) begin
        sel_nxt[k]   = 1'b1;
        region_found = 1'b1;
      end
    end
    sel_nxt[`ICB_PORT_NUM-1] = ~region_found;
  end

  assign o_cmd_ready = ~o_stg_valid | i_stg_ready;   // empty or draining this cycle
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_stg_valid <= 1'b0;
    end else if (o_cmd_ready) begin
      o_stg_valid <= i_cmd_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_hsk) begin
      o_stg_read  <= i_cmd_read;
      o_stg_addr  <= i_cmd_addr;
      o_stg_wdata <= i_cmd_wdata;
      o_stg_wmask <= i_cmd_wmask;
      o_stg_sel   <= sel_nxt;   // travels with its command
    end
  end

  a_stg_sel_onehot : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_stg_valid |-> $onehot(o_stg_sel)
  ) else $error("staged port select is not one-hot");

endmodule

`default_nettype wire

// File: design/icb_cmd_dispatch.sv
/*
 * dispatcher: drives the staged command onto its port and keeps
 * the port numbers of outstanding commands in issue order
 */
`timescale 1ns/1ps
`default_nettype none

`include "icb_splt_macros.svh"

module icb_cmd_dispatch (
  input  logic                                    i_clk,
  input  logic                                    i_rst_n,
  input  logic                                    i_stg_valid,
  output logic                                    o_stg_ready,
  input  logic                                    i_stg_read,
  input  icb_bus_pkg::icb_addr_t                  i_stg_addr,
  input  icb_bus_pkg::icb_data_t                  i_stg_wdata,
  input  icb_bus_pkg::icb_mask_t                  i_stg_wmask,
  input  icb_route_pkg::icb_port_sel_t            i_stg_sel,
  output logic [`ICB_PORT_NUM-1:0]                o_port_cmd_valid,
  input  logic [`ICB_PORT_NUM-1:0]                i_port_cmd_ready,
  output logic [`ICB_PORT_NUM-1:0]                o_port_cmd_read,
  output logic [`ICB_PORT_NUM-1:0][`ICB_AW-1:0]   o_port_cmd_addr,
  output icb_bus_pkg::icb_data_t [`ICB_PORT_NUM-1:0] o_port_cmd_wdata,
  output icb_bus_pkg::icb_mask_t [`ICB_PORT_NUM-1:0] o_port_cmd_wmask,
  output logic                                    o_head_valid,
  output icb_route_pkg::icb_port_idx_t            o_head_idx,
  input  logic                                    i_rsp_pop,
  output logic                                    o_active
);

  localparam int PTR_W = $clog2(`ICB_OUTS_DEPTH);
  localparam int CNT_W = $clog2(`ICB_OUTS_DEPTH + 1);

  icb_route_pkg::icb_port_idx_t order_q [`ICB_OUTS_DEPTH];
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  logic [CNT_W-1:0]             outs_cnt;
  logic                         q_full;
  logic                         push;
  icb_route_pkg::icb_port_idx_t sel_idx;

  assign q_full = (outs_cnt == CNT_W'(`ICB_OUTS_DEPTH));

  // only the selected port sees valid, and nothing issues while the queue is full
  assign o_port_cmd_valid = {`ICB_PORT_NUM{i_stg_valid & ~q_full}} & i_stg_sel;
  assign o_stg_ready      = ~q_full & |(i_stg_sel & i_port_cmd_ready);
  assign push             = |(o_port_cmd_valid & i_port_cmd_ready);

  for (genvar k = 0; k < `ICB_PORT_NUM; k++) begin : g_port
    assign o_port_cmd_read[k]  = i_stg_read;
    assign o_port_cmd_addr[k]  = i_stg_addr.raw;
    assign o_port_cmd_wdata[k] = i_stg_wdata;
    assign o_port_cmd_wmask[k] = i_stg_wmask;
  end

  always_comb begin
    sel_idx = '0;
    for (int k = 0; k < `ICB_PORT_NUM; k++) begin
      if (i_stg_sel[k]) begin
        sel_idx = icb_route_pkg::icb_port_idx_t'(k);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      outs_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_rsp_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      outs_cnt <= outs_cnt + CNT_W'(push) - CNT_W'(i_rsp_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      order_q[wr_ptr] <= sel_idx;
    end
  end

  assign o_head_valid = (outs_cnt != '0);
  assign o_head_idx   = order_q[rd_ptr];
  assign o_active     = i_stg_valid | o_head_valid;

  a_q_no_overflow : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    outs_cnt <= CNT_W'(`ICB_OUTS_DEPTH)
  ) else $error("order queue overflow");

  a_q_no_underflow : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_rsp_pop |-> o_head_valid
  ) else $error("response popped with no outstanding command");

endmodule

`default_nettype wire

// File: design/icb_rsp_return.sv
/*
 * response return: passes only the oldest outstanding port's
 * response upstream, which keeps responses in issue order
 */
`timescale 1ns/1ps
`default_nettype none

`include "icb_splt_macros.svh"

module icb_rsp_return (
  input  logic                                    i_head_valid,
  input  icb_route_pkg::icb_port_idx_t            i_head_idx,
  input  logic [`ICB_PORT_NUM-1:0]                i_port_rsp_valid,
  output logic [`ICB_PORT_NUM-1:0]                o_port_rsp_ready,
  input  logic [`ICB_PORT_NUM-1:0]                i_port_rsp_err,
  input  icb_bus_pkg::icb_data_t [`ICB_PORT_NUM-1:0] i_port_rsp_rdata,
  output logic                                    o_rsp_valid,
  input  logic                                    i_rsp_ready,
  output logic                                    o_rsp_err,
  output icb_bus_pkg::icb_data_t                  o_rsp_rdata,
  output logic                                    o_rsp_pop
);

  logic [`ICB_PORT_NUM-1:0] head_sel;

  assign head_sel = i_head_valid ? (`ICB_PORT_NUM'(1) << i_head_idx) : '0;

  // responses from any other port are held off until they reach the head
  assign o_port_rsp_ready = head_sel & {`ICB_PORT_NUM{i_rsp_ready}};

  assign o_rsp_valid = |(head_sel & i_port_rsp_valid);
  assign o_rsp_err   = i_port_rsp_err[i_head_idx];
  assign o_rsp_rdata = i_port_rsp_rdata[i_head_idx];
  assign o_rsp_pop   = o_rsp_valid & i_rsp_ready;   // upstream transfer retires the head

  always_comb begin
    a_one_rsp_ready : assert ($onehot0(o_port_rsp_ready))
      else $error("more than one port granted response ready");
  end

endmodule

`default_nettype wire

// File: design/icb_splt_top.sv
/*
 * one-to-six bus splitter: command stage, dispatcher with order
 * queue, and in-order response return
 */
`timescale 1ns/1ps
`default_nettype none

`include "icb_splt_macros.svh"

module icb_splt_top (
  input  logic                                    i_clk,
  input  logic                                    i_rst_n,
  input  logic                                    i_cmd_valid,
  output logic                                    o_cmd_ready,
  input  logic                                    i_cmd_read,
  input  icb_bus_pkg::icb_addr_t                  i_cmd_addr,
  input  icb_bus_pkg::icb_data_t                  i_cmd_wdata,
  input  icb_bus_pkg::icb_mask_t                  i_cmd_wmask,
  output logic                                    o_rsp_valid,
  input  logic                                    i_rsp_ready,
  output logic                                    o_rsp_err,
  output icb_bus_pkg::icb_data_t                  o_rsp_rdata,
  input  logic [`ICB_PORT_NUM-2:0]                i_port_enable,
  output logic [`ICB_PORT_NUM-1:0]                o_port_cmd_valid,
  input  logic [`ICB_PORT_NUM-1:0]                i_port_cmd_ready,
  output logic [`ICB_PORT_NUM-1:0]                o_port_cmd_read,
  output logic [`ICB_PORT_NUM-1:0][`ICB_AW-1:0]   o_port_cmd_addr,
  output icb_bus_pkg::icb_data_t [`ICB_PORT_NUM-1:0] o_port_cmd_wdata,
  output icb_bus_pkg::icb_mask_t [`ICB_PORT_NUM-1:0] o_port_cmd_wmask,
  input  logic [`ICB_PORT_NUM-1:0]                i_port_rsp_valid,
  output logic [`ICB_PORT_NUM-1:0]                o_port_rsp_ready,
  input  logic [`ICB_PORT_NUM-1:0]                i_port_rsp_err,
  input  icb_bus_pkg::icb_data_t [`ICB_PORT_NUM-1:0] i_port_rsp_rdata,
  output logic                                    o_active
);

  logic                         stg_valid;
  logic                         stg_ready;
  logic                         stg_read;
  icb_bus_pkg::icb_addr_t       stg_addr;
  icb_bus_pkg::icb_data_t       stg_wdata;
  icb_bus_pkg::icb_mask_t       stg_wmask;
  icb_route_pkg::icb_port_sel_t stg_sel;
  logic                         head_valid;
  icb_route_pkg::icb_port_idx_t head_idx;
  logic                         rsp_pop;

  icb_addr_decode u_decode (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_valid   (i_cmd_valid),
    .o_cmd_ready   (o_cmd_ready),
    .i_cmd_read    (i_cmd_read),
    .i_cmd_addr    (i_cmd_addr),
    .i_cmd_wdata   (i_cmd_wdata),
    .i_cmd_wmask   (i_cmd_wmask),
    .i_port_enable (i_port_enable),
    .o_stg_valid   (stg_valid),
    .i_stg_ready   (stg_ready),
    .o_stg_read    (stg_read),
    .o_stg_addr    (stg_addr),
    .o_stg_wdata   (stg_wdata),
    .o_stg_wmask   (stg_wmask),
    .o_stg_sel     (stg_sel)
  );

  icb_cmd_dispatch u_dispatch (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_stg_valid      (stg_valid),
    .o_stg_ready      (stg_ready),
    .i_stg_read       (stg_read),
    .i_stg_addr       (stg_addr),
    .i_stg_wdata      (stg_wdata),
    .i_stg_wmask      (stg_wmask),
    .i_stg_sel        (stg_sel),
    .o_port_cmd_valid (o_port_cmd_valid),
    .i_port_cmd_ready (i_port_cmd_ready),
    .o_port_cmd_read  (o_port_cmd_read),
    .o_port_cmd_addr  (o_port_cmd_addr),
    .o_port_cmd_wdata (o_port_cmd_wdata),
    .o_port_cmd_wmask (o_port_cmd_wmask),
    .o_head_valid     (head_valid),
    .o_head_idx       (head_idx),
    .i_rsp_pop        (rsp_pop),
    .o_active         (o_active)
  );

  icb_rsp_return u_return (
    .i_head_valid     (head_valid),
    .i_head_idx       (head_idx),
    .i_port_rsp_valid (i_port_rsp_valid),
    .o_port_rsp_ready (o_port_rsp_ready),
    .i_port_rsp_err   (i_port_rsp_err),
    .i_port_rsp_rdata (i_port_rsp_rdata),
    .o_rsp_valid      (o_rsp_valid),
    .i_rsp_ready      (i_rsp_ready),
    .o_rsp_err        (o_rsp_err),
    .o_rsp_rdata      (o_rsp_rdata),
    .o_rsp_pop        (rsp_pop)
  );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
/*
 * testbench clock source with a 4 ns period
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always #2 o_clk = ~o_clk;   // half of the period

endmodule

`default_nettype wire

// File: tb/icb_splt_tb.sv
/*
 * bus splitter testbench: random upstream commands, in-order port models
 * and a reference model of the routing rule and the response order
 */
`timescale 1ns/1ps
`default_nettype none

`include "icb_splt_macros.svh"

module icb_splt_tb;

  localparam int PORTS       = `ICB_PORT_NUM;
  localparam int PHASE_TXN   = 150;
  localparam int CYCLE_BOUND = 48;   // generous per-command bound under heavy back-pressure
  localparam int WATCHDOG_NS = (5 * PHASE_TXN * CYCLE_BOUND + 100) * 4;

  localparam logic [`ICB_AW-1:0] BASES [PORTS-1] = '{
    `ICB_BASE0, `ICB_BASE1, `ICB_BASE2, `ICB_BASE3, `ICB_BASE4
  };

  logic                               i_clk;
  logic                               i_rst_n;
  logic                               i_cmd_valid;
  logic                               o_cmd_ready;
  logic                               i_cmd_read;
  icb_bus_pkg::icb_addr_t             i_cmd_addr;
  icb_bus_pkg::icb_data_t             i_cmd_wdata;
  icb_bus_pkg::icb_mask_t             i_cmd_wmask;
  logic                               o_rsp_valid;
  logic                               i_rsp_ready;
  logic                               o_rsp_err;
  icb_bus_pkg::icb_data_t             o_rsp_rdata;
  logic [PORTS-2:0]                   i_port_enable;
  logic [PORTS-1:0]                   o_port_cmd_valid;
  logic [PORTS-1:0]                   i_port_cmd_ready;
  logic [PORTS-1:0]                   o_port_cmd_read;
  logic [PORTS-1:0][`ICB_AW-1:0]      o_port_cmd_addr;
  icb_bus_pkg::icb_data_t [PORTS-1:0] o_port_cmd_wdata;
  icb_bus_pkg::icb_mask_t [PORTS-1:0] o_port_cmd_wmask;
  logic [PORTS-1:0]                   i_port_rsp_valid;
  logic [PORTS-1:0]                   o_port_rsp_ready;
  logic [PORTS-1:0]                   i_port_rsp_err;
  icb_bus_pkg::icb_data_t [PORTS-1:0] i_port_rsp_rdata;
  logic                               o_active;

  integer                 seed = 32'h1854_c07f;
  string                  test_name;
  int                     errors = 0;
  int                     checks = 0;
  int                     tests_run = 0;
  int                     accepted = 0;      // upstream command transfers in this phase
  int                     outstanding = 0;   // issued at the ports and not yet answered upstream
  int                     rdy_pct = 0;
  int                     rsp_pct = 0;
  logic                   cmd_taken = 1'b0;
  logic [PORTS-1:0]       rsp_taken = '0;
  logic [112:0]           exp_cmd_q [$];     // port, read, addr, wdata, wmask
  logic [64:0]            exp_rsp_q [$];     // err above rdata
  icb_bus_pkg::icb_data_t port_q [PORTS][$];

  tb_clk_gen u_clk_gen (
    .o_clk (i_clk)
  );

  icb_splt_top i_dut (.*);

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic chance(int pct);
    return int'(rand_word() % 32'd100) < pct;
  endfunction

  // five in eight addresses land inside a region, the rest are random words
  function automatic logic [`ICB_AW-1:0] pick_addr();
    logic [31:0] r;
    logic [31:0] sel;
    r   = rand_word();
    sel = rand_word();
    if (sel[2:0] < 3'd5) begin
      return BASES[sel[2:0]] | (r & 32'h0000_0fff);
    end
    return r;
  endfunction

  // lowest enabled region with a matching tag wins, otherwise the default port
  function automatic logic [7:0] route_of(logic [`ICB_AW-1:0] addr, logic [PORTS-2:0] en);
    for (int k = 0; k < PORTS - 1; k++) begin
      if (en[k] && addr[`ICB_AW-1:`ICB_REGION_LSB] ==
          BASES[k][`ICB_AW-1:`ICB_REGION_LSB]) begin
        return 8'(k);
      end
    end
    return 8'(PORTS - 1);
  endfunction

  task automatic compare_value(string what, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report_error(string msg);
    errors++;
    $display("error in test %s: %s", test_name, msg);
  endtask

  // drive 1 ns after the rising edge, sample at the falling edge when all is settled
  task automatic step_cycle();
    logic [31:0]  r;
    logic [7:0]   p;
    logic [112:0] rec;
    logic [64:0]  exp_rsp;
    logic         exp_ready;
    logic [63:0]  exp_valid;
    @(posedge i_clk);
    #1;
    if (!i_cmd_valid || cmd_taken) begin
      r              = rand_word();
      i_cmd_valid    = (accepted < PHASE_TXN) && chance(70);
      i_cmd_read     = r[0];
      i_cmd_wmask    = r[15:8];
      i_cmd_addr.raw = pick_addr();
      i_cmd_wdata    = {rand_word(), rand_word()};
    end
    for (int k = 0; k < PORTS; k++) begin
      if (rsp_taken[k]) begin
        void'(port_q[k].pop_front());
        i_port_rsp_valid[k] = 1'b0;
      end
      if (!i_port_rsp_valid[k] && port_q[k].size() != 0 && chance(rsp_pct)) begin
        i_port_rsp_valid[k] = 1'b1;
        i_port_rsp_rdata[k] = port_q[k][0];
        i_port_rsp_err[k]   = (k == PORTS - 1);   // only the default port reports errors
      end
      i_port_cmd_ready[k] = chance(rdy_pct);
    end
    i_rsp_ready = chance(rdy_pct);
    @(negedge i_clk);
    // the stage holds the oldest command that no port has taken yet
    exp_ready = (exp_cmd_q.size() == 0);
    exp_valid = '0;
    if (exp_cmd_q.size() != 0 && outstanding < `ICB_OUTS_DEPTH) begin
      p         = exp_cmd_q[0][112:105];
      exp_valid = 64'(1) << p;
      exp_ready = i_port_cmd_ready[p];
    end
    compare_value("cmd_valid", exp_valid, 64'(o_port_cmd_valid));
    compare_value("cmd_ready", 64'(exp_ready), 64'(o_cmd_ready));
    cmd_taken = i_cmd_valid & o_cmd_ready;
    if (cmd_taken) begin
      p = route_of(i_cmd_addr.raw, i_port_enable);
      exp_cmd_q.push_back({p, i_cmd_read, i_cmd_addr.raw, i_cmd_wdata, i_cmd_wmask});
      exp_rsp_q.push_back({(p == 8'(PORTS - 1)), p, 24'h0, i_cmd_addr.raw});
      accepted++;
    end
    if ($countones(o_port_cmd_valid) > 1) begin
      report_error("command valid raised on more than one port");
    end
    for (int k = 0; k < PORTS; k++) begin
      if (o_port_cmd_valid[k] && i_port_cmd_ready[k]) begin
        if (exp_cmd_q.size() == 0) begin
          report_error("a port took a command that was never sent upstream");
        end else begin
          rec = exp_cmd_q.pop_front();
          compare_value("cmd_port", 64'(rec[112:105]), 64'(k));
          compare_value("cmd_read", 64'(rec[104]), 64'(o_port_cmd_read[k]));
          compare_value("cmd_addr", 64'(rec[103:72]), 64'(o_port_cmd_addr[k]));
          compare_value("cmd_wdata", rec[71:8], o_port_cmd_wdata[k]);
          compare_value("cmd_wmask", 64'(rec[7:0]), 64'(o_port_cmd_wmask[k]));
        end
        port_q[k].push_back({8'(k), 24'h0, o_port_cmd_addr[k]});
        outstanding++;
        if (outstanding > `ICB_OUTS_DEPTH) begin
          report_error("more commands outstanding at the ports than the order queue holds");
        end
      end
    end
    rsp_taken = i_port_rsp_valid & o_port_rsp_ready;
    if (o_rsp_valid && i_rsp_ready) begin
      if (exp_rsp_q.size() == 0) begin
        report_error("upstream response arrived with no command outstanding");
      end else begin
        exp_rsp = exp_rsp_q.pop_front();
        compare_value("rsp_err", 64'(exp_rsp[64]), 64'(o_rsp_err));
        compare_value("rsp_rdata", exp_rsp[63:0], o_rsp_rdata);
      end
      outstanding--;
    end
  endtask

  task automatic run_phase(string name, logic [PORTS-2:0] en, int ready_pct, int valid_pct);
    int err_start;
    err_start     = errors;
    test_name     = name;
    rdy_pct       = ready_pct;
    rsp_pct       = valid_pct;
    accepted      = 0;
    @(posedge i_clk);
    #1;
    i_port_enable = en;   // changed only while the DUT is idle
    while (accepted < PHASE_TXN || exp_rsp_q.size() != 0) begin
      step_cycle();
    end
    step_cycle();   // the last response retires from the order queue here
    compare_value("active", 64'd0, 64'(o_active));
    compare_value("port_cmd_valid", 64'd0, 64'(o_port_cmd_valid));
    tests_run++;
    $display("test %-12s done: %0d commands, %0d errors", name, accepted, errors - err_start);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

  initial begin
    logic [31:0] en_word;
    i_rst_n          = 1'b0;
    i_cmd_valid      = 1'b0;
    i_cmd_read       = 1'b0;
    i_cmd_addr.raw   = '0;
    i_cmd_wdata      = '0;
    i_cmd_wmask      = '0;
    i_rsp_ready      = 1'b0;
    i_port_enable    = '1;
    i_port_cmd_ready = '0;
    i_port_rsp_valid = '0;
    i_port_rsp_err   = '0;
    i_port_rsp_rdata = '0;
    test_name        = "reset";
    repeat (8) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(negedge i_clk);
    compare_value("port_cmd_valid", 64'd0, 64'(o_port_cmd_valid));
    compare_value("port_rsp_ready", 64'd0, 64'(o_port_rsp_ready));
    compare_value("rsp_valid", 64'd0, 64'(o_rsp_valid));
    compare_value("active", 64'd0, 64'(o_active));
    tests_run++;
    $display("test %-12s done: %0d errors", test_name, errors);
    run_phase("routing", 5'b11111, 90, 80);
    en_word = rand_word();
    run_phase("enables_a", en_word[4:0] & 5'b11110, 80, 60);
    en_word = rand_word();
    run_phase("enables_b", en_word[4:0], 80, 60);
    run_phase("ordering", 5'b11111, 100, 20);   // slow random answers let later ports finish first
    run_phase("backpressure", 5'b11111, 30, 50);
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/icb_bus_pkg.sv
design/icb_route_pkg.sv
design/icb_addr_decode.sv
design/icb_cmd_dispatch.sv
design/icb_rsp_return.sv
design/icb_splt_top.sv
tb/tb_clk_gen.sv
tb/icb_splt_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the bus splitter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module icb_splt_tb -o icb_splt_sim

out="$(./obj_dir/icb_splt_sim 2>&1 || true)"
printf '%s\n' "$out"

if ! grep -qx "sim passed" <<< "$out"; then
  exit 1
fi
